// File: sim.f
src/sram_pkg.sv
src/array_pkg.sv
src/fetch_sequencer.sv
src/window_former.sv
src/systolic_skew.sv
src/feeder_top.sv
sim/sram_model.sv
sim/tb_feeder.sv

// File: sim/sram_model.sv
module sram_model #(
    parameter int ADDR_W = 16,
    parameter int WORD_W = 64
) (
    input  logic              i_clk,
    input  logic              i_rden,
    input  logic [ADDR_W-1:0] i_addr,
    output logic [WORD_W-1:0] o_data
);

    timeunit 1ns;
    timeprecision 1ps;

    // Contents are written directly by the testbench
    logic [WORD_W-1:0] mem [2**ADDR_W];

    ////////////////////////////////////////
    // Read port
    ////////////////////////////////////////

    // Data appears one cycle after a read and holds otherwise
    always_ff @(posedge i_clk) begin
        if (i_rden) begin
            o_data <= mem[i_addr];
        end
    end

endmodule

// File: sim/tb_feeder.sv
module tb_feeder;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int ADDR_W    = 16;
    localparam int SKEW_STEP = 3;
    localparam int NUM_TESTS = 8;
    localparam int SLACK     = 64;

    localparam logic [1:0] FILL_RANDOM = 2'd0;
    localparam logic [1:0] FILL_MAX    = 2'd1;
    localparam logic [1:0] FILL_MIN    = 2'd2;

    typedef struct packed {
        logic [7:0] channel;
        logic [7:0] height;
        logic [1:0] fill;
    } test_entry_t;

    logic                           i_clk;
    logic                           i_rst;
    logic                           i_start;
    logic [7:0]                     i_channel;
    logic [array_pkg::HEIGHT_W-1:0] i_img_height;
    logic                           o_sram_rden;
    logic [ADDR_W-1:0]              o_sram_addr;
    logic [sram_pkg::WORD_W-1:0]    sram_data;
    array_pkg::skewed_out_t         o_win;
    logic                           o_busy;
    logic                           o_done;

    test_entry_t tests [NUM_TESTS];
    logic [63:0] img_words [256];
    logic [23:0] top_q [$];
    logic [23:0] mid_q [$];
    logic [23:0] bot_q [$];
    integer      seed;
    int          mismatches;
    int          other_errors;

    feeder_top #(
        .ADDR_W       (ADDR_W),
        .SKEW_STEP    (SKEW_STEP)
    ) i_dut (
        .i_clk        (i_clk),
        .i_rst        (i_rst),
        .i_start      (i_start),
        .i_channel    (i_channel),
        .i_img_height (i_img_height),
        .o_sram_rden  (o_sram_rden),
        .o_sram_addr  (o_sram_addr),
        .i_sram_data  (sram_data),
        .o_win        (o_win),
        .o_busy       (o_busy),
        .o_done       (o_done)
    );

    sram_model #(
        .ADDR_W (ADDR_W),
        .WORD_W (sram_pkg::WORD_W)
    ) i_sram (
        .i_clk  (i_clk),
        .i_rden (o_sram_rden),
        .i_addr (o_sram_addr),
        .o_data (sram_data)
    );

    initial begin
        i_clk = 1'b0;
        forever #2 i_clk = ~i_clk;
    end

    ////////////////////////////////////////
    // Stimulus table and reference
    ////////////////////////////////////////

    // Channel, height, fill
    task automatic load_table();
        tests[0] = {8'd0,   8'd4,   FILL_RANDOM};
        tests[1] = {8'd3,   8'd5,   FILL_RANDOM};
        tests[2] = {8'd1,   8'd1,   FILL_RANDOM};
        tests[3] = {8'd2,   8'd6,   FILL_MAX};
        tests[4] = {8'd5,   8'd3,   FILL_MIN};
        tests[5] = {8'd9,   8'd2,   FILL_RANDOM};
        tests[6] = {8'd1,   8'd255, FILL_RANDOM};
        tests[7] = {8'd255, 8'd7,   FILL_RANDOM};
    endtask

    // Every word differs, so a stray address shows up in the data
    task automatic fill_background();
        logic [15:0] a16;
        for (int a = 0; a < 2**ADDR_W; a++) begin
            a16 = 16'(a);
            i_sram.mem[a] = {~a16, a16 ^ 16'hc3a5, a16, a16 + 16'h1357};
        end
    endtask

    task automatic fill_image(input int channel, input int height, input logic [1:0] fill);
        int          base;
        logic [63:0] word;
        base = channel * height;
        for (int r = 0; r < height; r++) begin
            case (fill)
                FILL_MAX: word = {8{8'h7f}};
                FILL_MIN: word = {8{8'h80}};
                default:  word = {$random(seed), $random(seed)};
            endcase
            img_words[r]         = word;
            i_sram.mem[base + r] = word;
        end
    endtask

    // Zero outside the image on every side
    function automatic logic [7:0] image_pixel(int row, int col, int height);
        if (row < 0 || row >= height || col < 0 || col >= 8) begin
            return 8'h00;
        end
        return img_words[row][8*col +: 8];
    endfunction

    function automatic logic [23:0] expected_row(int r, int c, int k, int height);
        int ir;
        ir = r - 1 + k;
        return {image_pixel(ir, c - 1, height), image_pixel(ir, c, height),
                image_pixel(ir, c + 1, height)};
    endfunction

    function automatic int stream_size(int k);
        case (k)
            0:       return top_q.size();
            1:       return mid_q.size();
            default: return bot_q.size();
        endcase
    endfunction

    function automatic logic [23:0] stream_elem(int k, int i);
        case (k)
            0:       return top_q[i];
            1:       return mid_q[i];
            default: return bot_q[i];
        endcase
    endfunction

    ////////////////////////////////////////
    // Driving and checking
    ////////////////////////////////////////

    task automatic compare(input string name, input logic [63:0] exp, input logic [63:0] got);
        if (got !== exp) begin
            $display("MISMATCH t=%0t %s expected %0h got %0h", $time, name, exp, got);
            mismatches++;
        end
    endtask

    task automatic pulse_start(input logic [7:0] channel, input logic [7:0] height);
        @(posedge i_clk);
        i_start      <= 1'b1;
        i_channel    <= channel;
        i_img_height <= height;
        // Done of the previous run must already be gone
        @(negedge i_clk);
        compare("o_done", 64'd0, o_done);
        compare("o_busy", 64'd0, o_busy);
        @(posedge i_clk);
        i_start <= 1'b0;
        @(negedge i_clk);
        compare("o_busy", 64'd1, o_busy);
    endtask

    task automatic collect_run(input int height, input int base, output bit timed_out);
        int cycles;
        bit done_seen;
        top_q.delete();
        mid_q.delete();
        bot_q.delete();
        cycles    = 0;
        done_seen = 1'b0;
        timed_out = 1'b0;
        while (!done_seen && !timed_out) begin
            @(negedge i_clk);
            if (o_win[0].valid) top_q.push_back(o_win[0].data);
            if (o_win[1].valid) mid_q.push_back(o_win[1].data);
            if (o_win[2].valid) bot_q.push_back(o_win[2].data);
            if (o_sram_rden) begin
                if (int'(o_sram_addr) < base || int'(o_sram_addr) >= base + height) begin
                    $display("ERROR: t=%0t read of address %0d outside channel region %0d..%0d",
                             $time, o_sram_addr, base, base + height - 1);
                    other_errors++;
                end
            end
            if (o_done) begin
                done_seen = 1'b1;
                compare("o_busy", 64'd0, o_busy);
            end
            cycles++;
            if (!done_seen && cycles >= height * 8 + SLACK) begin
                timed_out = 1'b1;
            end
        end
        if (timed_out) begin
            $display("ERROR: t=%0t no o_done within %0d cycles", $time, cycles);
            other_errors++;
        end
    endtask

    task automatic check_streams(input int height);
        int          n;
        int          got_n;
        logic [23:0] got;
        logic [23:0] exp;
        n = height * 8;
        for (int k = 0; k < array_pkg::KERNEL; k++) begin
            got_n = stream_size(k);
            if (got_n != n) begin
                $display("ERROR: kernel row %0d carried %0d elements instead of %0d",
                         k, got_n, n);
                other_errors++;
            end
            for (int i = 0; i < n && i < got_n; i++) begin
                got = stream_elem(k, i);
                exp = expected_row(i / 8, i % 8, k, height);
                compare($sformatf("o_win[%0d].data row %0d col %0d", k, i / 8, i % 8),
                        64'(exp), 64'(got));
            end
        end
    endtask

    ////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////

    initial begin : main
        bit          timed_out;
        test_entry_t t;
        seed         = 32'h861df6c8;
        mismatches   = 0;
        other_errors = 0;
        timed_out    = 1'b0;
        i_rst        = 1'b1;
        i_start      = 1'b0;
        i_channel    = 8'd0;
        i_img_height = 8'd1;
        load_table();
        fill_background();

        repeat (16) @(posedge i_clk);
        i_rst <= 1'b0;
        @(negedge i_clk);
        compare("o_busy", 64'd0, o_busy);
        compare("o_done", 64'd0, o_done);
        compare("o_sram_rden", 64'd0, o_sram_rden);
        for (int k = 0; k < array_pkg::KERNEL; k++) begin
            compare($sformatf("o_win[%0d].valid", k), 64'd0, o_win[k].valid);
        end

        for (int n = 0; n < NUM_TESTS && !timed_out; n++) begin
            t = tests[n];
            fill_image(int'(t.channel), int'(t.height), t.fill);
            pulse_start(t.channel, t.height);
            collect_run(int'(t.height), int'(t.channel) * int'(t.height), timed_out);
            if (!timed_out) begin
                check_streams(int'(t.height));
            end
        end

        // Single cycle done after the final run
        @(negedge i_clk);
        compare("o_done", 64'd0, o_done);

        $display("Summary: %0d mismatches, %0d other errors", mismatches, other_errors);
        if (mismatches == 0 && other_errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// File: src/array_pkg.sv
package array_pkg;

    localparam int KERNEL   = 3;
    localparam int HEIGHT_W = 8;

    typedef logic signed [7:0] pixel_t;

    // One kernel row of a window
    typedef struct packed {
        pixel_t left;
        pixel_t centre;
        pixel_t right;
    } kernel_row_t;

    // Index 0 is the top kernel row
    typedef kernel_row_t [KERNEL-1:0] window_t;

    // Kernel row as seen by the array after skewing
    typedef struct packed {
        logic        valid;
        kernel_row_t data;
    } skew_lane_t;

    typedef skew_lane_t [KERNEL-1:0] skewed_out_t;

endpackage

// File: src/feeder_top.sv
module feeder_top #(
    parameter int ADDR_W    = 16,
    parameter int SKEW_STEP = 3
) (
    input  logic                            i_clk,
    input  logic                            i_rst,
    input  logic                            i_start,
    input  logic [7:0]                      i_channel,
    input  logic [array_pkg::HEIGHT_W-1:0]  i_img_height,
    output logic                            o_sram_rden,
    output logic [ADDR_W-1:0]               o_sram_addr,
    input  logic [sram_pkg::WORD_W-1:0]     i_sram_data,
    output array_pkg::skewed_out_t          o_win,
    output logic                            o_busy,
    output logic                            o_done
);

    logic                   busy_q;
    logic                   start_ok;
    logic                   fetch_busy;
    logic                   tag_valid;
    sram_pkg::fetch_tag_t   tag;
    sram_pkg::sram_word_u   sram_word;
    logic                   win_valid;
    array_pkg::window_t     win;
    logic                   win_last;
    logic                   skew_empty;

    assign start_ok      = i_start && !busy_q;
    assign sram_word.raw = i_sram_data;
    assign o_busy        = busy_q;

    ////////////////////////////////////////
    // Run flag
    ////////////////////////////////////////

    // Held until fetch is idle and the skew stage drains
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            busy_q <= 1'b0;
        end else if (start_ok) begin
            busy_q <= 1'b1;
        end else if (!fetch_busy && skew_empty) begin
            busy_q <= 1'b0;
        end
    end

    fetch_sequencer #(
        .ADDR_W       (ADDR_W)
    ) i_fetch (
        .i_clk        (i_clk),
        .i_rst        (i_rst),
        .i_start      (start_ok),
        .i_channel    (i_channel),
        .i_img_height (i_img_height),
        .o_sram_rden  (o_sram_rden),
        .o_sram_addr  (o_sram_addr),
        .o_tag_valid  (tag_valid),
        .o_tag        (tag),
        .o_busy       (fetch_busy)
    );

    window_former i_former (
        .i_clk        (i_clk),
        .i_rst        (i_rst),
        .i_tag_valid  (tag_valid),
        .i_tag        (tag),
        .i_sram_data  (sram_word),
        .o_win_valid  (win_valid),
        .o_win        (win),
        .o_win_last   (win_last)
    );

    systolic_skew #(
        .SKEW_STEP    (SKEW_STEP)
    ) i_skew (
        .i_clk        (i_clk),
        .i_rst        (i_rst),
        .i_win_valid  (win_valid),
        .i_win        (win),
        .i_win_last   (win_last),
        .o_win        (o_win),
        .o_done       (o_done),
        .o_empty      (skew_empty)
    );

    // Done closes a run that was busy, and busy falls with it
    a_done_ends_run : assert property (
        @(posedge i_clk) disable iff (i_rst) o_done |-> (!o_busy && $past(o_busy))
    );

endmodule

// File: src/fetch_sequencer.sv
module fetch_sequencer #(
    parameter int ADDR_W = 16
) (
    input  logic                            i_clk,
    input  logic                            i_rst,
    input  logic                            i_start,
    input  logic [7:0]                      i_channel,
    input  logic [array_pkg::HEIGHT_W-1:0]  i_img_height,
    output logic                            o_sram_rden,
    output logic [ADDR_W-1:0]               o_sram_addr,
    output logic                            o_tag_valid,
    output sram_pkg::fetch_tag_t            o_tag,
    output logic                            o_busy
);

    // One output row per period of PIX_PER_WORD cycles
    localparam int PHASE_W = $clog2(sram_pkg::PIX_PER_WORD);
    localparam logic [PHASE_W-1:0] LAST_PHASE = PHASE_W'(sram_pkg::PIX_PER_WORD - 1);
    localparam int ROW_EXT_W = array_pkg::HEIGHT_W + 2;

    logic                           busy_q;
    logic [array_pkg::HEIGHT_W-1:0] row_q;
    logic [PHASE_W-1:0]             phase_q;
    logic [ADDR_W-1:0]              base_q;

    logic signed [ROW_EXT_W-1:0]    img_row;
    logic                           slot_active;
    logic                           slot_pad;
    logic                           last_row;

    ////////////////////////////////////////
    // Slot decode
    ////////////////////////////////////////

    // Slot k of row r reads image row r-1+k
    assign img_row = {2'b00, row_q} + ROW_EXT_W'(phase_q) - ROW_EXT_W'(1);

    assign slot_active = busy_q && (phase_q < PHASE_W'(array_pkg::KERNEL));
    assign slot_pad    = (img_row < 0) || (img_row >= $signed({2'b00, i_img_height}));
    assign last_row    = (row_q == i_img_height - 1'b1);

    assign o_sram_rden = slot_active && !slot_pad;
    assign o_sram_addr = base_q + ADDR_W'(img_row[array_pkg::HEIGHT_W-1:0]);
    assign o_busy      = busy_q;

    ////////////////////////////////////////
    // Row and phase counters
    ////////////////////////////////////////

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            busy_q      <= 1'b0;
            row_q       <= '0;
            phase_q     <= '0;
            o_tag_valid <= 1'b0;
        end else begin
            o_tag_valid <= slot_active;
            if (!busy_q) begin
                if (i_start) begin
                    busy_q  <= 1'b1;
                    row_q   <= '0;
                    phase_q <= '0;
                end
            end else begin
                phase_q <= phase_q + 1'b1;
                if (phase_q == LAST_PHASE) begin
                    row_q <= row_q + 1'b1;
                    if (last_row) begin
                        busy_q <= 1'b0;
                    end
                end
            end
        end
    end

    // Tag lags the read by one cycle to meet the SRAM data
    always_ff @(posedge i_clk) begin
        if (!busy_q && i_start) begin
            base_q <= ADDR_W'(i_channel) * ADDR_W'(i_img_height);
        end
        o_tag.slot <= phase_q[1:0];
        o_tag.pad  <= slot_pad;
        o_tag.last <= last_row && (phase_q == PHASE_W'(array_pkg::KERNEL - 1));
    end

    // Pad and last row decode use the live height for the whole run
    a_height_stable : assert property (
        @(posedge i_clk) disable iff (i_rst) busy_q |-> $stable(i_img_height)
    );

endmodule

// File: src/sram_pkg.sv
package sram_pkg;

    // One word holds one full image row
    localparam int WORD_W       = 64;
    localparam int PIX_PER_WORD = 8;
    localparam int LANE_W       = WORD_W / PIX_PER_WORD;

    // Lane 0 sits in bits 7:0 and is the leftmost pixel
    typedef union packed {
        logic [WORD_W-1:0]                    raw;
        logic [PIX_PER_WORD-1:0][LANE_W-1:0]  lane;
    } sram_word_u;

    // Travels with every read slot and lines up with the returned data
    typedef struct packed {
        logic [1:0] slot;
        logic       pad;
        logic       last;
    } fetch_tag_t;

endpackage

// File: src/systolic_skew.sv
module systolic_skew #(
    parameter int SKEW_STEP = 3
) (
    input  logic                    i_clk,
    input  logic                    i_rst,
    input  logic                    i_win_valid,
    input  array_pkg::window_t      i_win,
    input  logic                    i_win_last,
    output array_pkg::skewed_out_t  o_win,
    output logic                    o_done,
    output logic                    o_empty
);

    localparam int R2_LEN = 2 * SKEW_STEP;

    logic [SKEW_STEP-1:0]   r1_valid_q;
    array_pkg::kernel_row_t r1_data_q [SKEW_STEP];
    logic [R2_LEN-1:0]      r2_valid_q;
    logic [R2_LEN-1:0]      r2_last_q;
    array_pkg::kernel_row_t r2_data_q [R2_LEN];

    // Stage 0 takes the input and the top stage feeds the array
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            r1_valid_q <= '0;
            r2_valid_q <= '0;
            r2_last_q  <= '0;
            o_done     <= 1'b0;
        end else begin
            r1_valid_q[0] <= i_win_valid;
            for (int i = 1; i < SKEW_STEP; i++) begin
                r1_valid_q[i] <= r1_valid_q[i-1];
            end
            r2_valid_q[0] <= i_win_valid;
            r2_last_q[0]  <= i_win_valid && i_win_last;
            for (int i = 1; i < R2_LEN; i++) begin
                r2_valid_q[i] <= r2_valid_q[i-1];
                r2_last_q[i]  <= r2_last_q[i-1];
            end
            o_done <= r2_valid_q[R2_LEN-1] && r2_last_q[R2_LEN-1];
        end
    end

    always_ff @(posedge i_clk) begin
        r1_data_q[0] <= i_win[1];
        for (int i = 1; i < SKEW_STEP; i++) begin
            r1_data_q[i] <= r1_data_q[i-1];
        end
        r2_data_q[0] <= i_win[2];
        for (int i = 1; i < R2_LEN; i++) begin
            r2_data_q[i] <= r2_data_q[i-1];
        end
    end

    always_comb begin
        o_win[0].valid = i_win_valid;
        o_win[0].data  = i_win[0];
        o_win[1].valid = r1_valid_q[SKEW_STEP-1];
        o_win[1].data  = r1_data_q[SKEW_STEP-1];
        o_win[2].valid = r2_valid_q[R2_LEN-1];
        o_win[2].data  = r2_data_q[R2_LEN-1];
    end

    // Row 2 chain is the longest, so it covers everything in flight.
    // Empty means nothing remains once the output stage has gone out.
    always_comb begin
        o_empty = !i_win_valid;
        for (int i = 0; i < R2_LEN - 1; i++) begin
            if (r2_valid_q[i]) begin
                o_empty = 1'b0;
            end
        end
    end

endmodule

// File: src/window_former.sv
module window_former (
    input  logic                  i_clk,
    input  logic                  i_rst,
    input  logic                  i_tag_valid,
    input  sram_pkg::fetch_tag_t  i_tag,
    input  sram_pkg::sram_word_u  i_sram_data,
    output logic                  o_win_valid,
    output array_pkg::window_t    o_win,
    output logic                  o_win_last
);

    localparam int COL_W = $clog2(sram_pkg::PIX_PER_WORD);
    localparam logic [COL_W-1:0] LAST_COL = COL_W'(sram_pkg::PIX_PER_WORD - 1);

    sram_pkg::sram_word_u word_in;
    sram_pkg::sram_word_u stage0_q;
    sram_pkg::sram_word_u stage1_q;
    sram_pkg::sram_word_u blk_q [array_pkg::KERNEL];

    logic                 load;
    logic                 emit_q;
    logic                 last_q;
    logic [COL_W-1:0]     col_q;

    // Rows outside the image read as zero
    assign word_in.raw = i_tag.pad ? '0 : i_sram_data.raw;
    assign load        = i_tag_valid && (i_tag.slot == 2'd2);

    ////////////////////////////////////////
    // Row capture
    ////////////////////////////////////////

    always_ff @(posedge i_clk) begin
        if (i_tag_valid && (i_tag.slot == 2'd0)) begin
            stage0_q <= word_in;
        end
        if (i_tag_valid && (i_tag.slot == 2'd1)) begin
            stage1_q <= word_in;
        end
        if (load) begin
            blk_q[0] <= stage0_q;
            blk_q[1] <= stage1_q;
            blk_q[2] <= word_in;
        end
    end

    // Column walk over the loaded block
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            emit_q <= 1'b0;
            last_q <= 1'b0;
            col_q  <= '0;
        end else if (load) begin
            emit_q <= 1'b1;
            last_q <= i_tag.last;
            col_q  <= '0;
        end else if (emit_q) begin
            col_q <= col_q + 1'b1;
            if (col_q == LAST_COL) begin
                emit_q <= 1'b0;
            end
        end
    end

    ////////////////////////////////////////
    // Window taps
    ////////////////////////////////////////

    // Left and right borders are word edges
    always_comb begin
        for (int k = 0; k < array_pkg::KERNEL; k++) begin
            o_win[k].centre = array_pkg::pixel_t'(blk_q[k].lane[col_q]);
            if (col_q == '0) begin
                o_win[k].left = '0;
            end else begin
                o_win[k].left = array_pkg::pixel_t'(blk_q[k].lane[col_q - COL_W'(1)]);
            end
            if (col_q == LAST_COL) begin
                o_win[k].right = '0;
            end else begin
                o_win[k].right = array_pkg::pixel_t'(blk_q[k].lane[col_q + COL_W'(1)]);
            end
        end
    end

    assign o_win_valid = emit_q;
    assign o_win_last  = emit_q && last_q && (col_q == LAST_COL);

    // A block may only be replaced while its last column goes out
    a_no_overwrite : assert property (
        @(posedge i_clk) disable iff (i_rst) load |-> (!emit_q || col_q == LAST_COL)
    );

endmodule
